/* bt656_pkg.sv */
package bt656_pkg;

   // one byte per sample on the embedded-sync bus
   localparam int SAMPLE_W = 8;

   // timing reference preamble is FF 00 00 XY
   localparam logic [7:0] PREAMBLE_FF = 8'hFF;
   localparam logic [7:0] PREAMBLE_00 = 8'h00;
   localparam int PREAMBLE_LEN = 4;

   // bit positions inside the XY byte
   localparam int HDR_BIT_ONE    = 7;
   localparam int HDR_BIT_FIELD  = 6;
   localparam int HDR_BIT_VBLANK = 5;
   localparam int HDR_BIT_HBLANK = 4;

   localparam int CNT_W = 12;

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [CNT_W-1:0]    size_t;

   // all ones means nothing measured yet
   localparam size_t CNT_UNSET = '1;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_SAV,
      RX_BLANKING,
      RX_VDATA
   } rx_state_t;

endpackage

/* stream_pkg.sv */
package stream_pkg;

   // sample FIFO between framer and output stage
   localparam int FIFO_DEPTH = 64;
   localparam int FIFO_AW    = 6;

   localparam int FRAME_CNT_W = 16;

   typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

   // output stream FSM
   typedef enum logic [1:0] {
      OUT_IDLE,
      OUT_SOF,
      OUT_DATA
   } out_state_t;

endpackage

/* video_timing_if.sv */
`timescale 1ns/1ns

interface video_timing_if
   import bt656_pkg::*;
();

   // oldest byte of the input delay line
   sample_t tap;
   // preamble at tap, plus its H-bit split
   logic    hdr;
   logic    sav;
   logic    eav;
   // flags held from the last header
   logic    vblank;
   logic    field;

   modport src (output tap, hdr, sav, eav, vblank, field);
   modport snk (input tap, hdr, sav, eav, vblank, field);

endinterface

/* pixel_stream_if.sv */
`timescale 1ns/1ns

interface pixel_stream_if
   import bt656_pkg::*;
();

   sample_t data;
   // first sample of a frame
   logic    sof;
   // final sample of a line
   logic    last;
   logic    valid;
   logic    ready;

   modport src (output data, sof, last, valid, input ready);
   modport snk (input data, sof, last, valid, output ready);

endinterface

/* bt656_header_detect.sv */
`timescale 1ns/1ns

module bt656_header_detect
   import bt656_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   input  sample_t     video_i,
   video_timing_if.src timing
);

   sample_t dly [PREAMBLE_LEN];
   sample_t xy;
   logic    hdr;
   logic    vblank_q;
   logic    field_q;

   // delay line, dly[0] is the newest byte
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < PREAMBLE_LEN; i++)
         begin
            dly[i] <= '0;
         end
      end
      else
      begin
         dly[0] <= video_i;
         for (int i = 1; i < PREAMBLE_LEN; i++)
         begin
            dly[i] <= dly[i-1];
         end
      end
   end

   assign xy  = dly[0];
   assign hdr = (dly[PREAMBLE_LEN-1] == PREAMBLE_FF) &&
                (dly[PREAMBLE_LEN-2] == PREAMBLE_00) &&
                (dly[PREAMBLE_LEN-3] == PREAMBLE_00) &&
                xy[HDR_BIT_ONE];

   // V and F only change on a valid header
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vblank_q <= 1'b0;
         field_q  <= 1'b0;
      end
      else if (hdr)
      begin
         vblank_q <= xy[HDR_BIT_VBLANK];
         field_q  <= xy[HDR_BIT_FIELD];
      end
   end

   assign timing.tap    = dly[PREAMBLE_LEN-1];
   assign timing.hdr    = hdr;
   assign timing.sav    = hdr && !xy[HDR_BIT_HBLANK];
   assign timing.eav    = hdr && xy[HDR_BIT_HBLANK];
   assign timing.vblank = vblank_q;
   assign timing.field  = field_q;

endmodule

/* bt656_line_framer.sv */
`timescale 1ns/1ns

module bt656_line_framer
   import bt656_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   video_timing_if.snk timing,
   pixel_stream_if.src wr
);

   rx_state_t  state;
   rx_state_t  state_nx;
   logic       field_d;
   logic       new_frame;
   logic       sav_d;
   logic [1:0] skip;
   logic       capture;
   logic       line_end;
   logic       sof_pending;
   logic       hold_valid;
   logic       hold_sof;
   sample_t    hold_data;
   logic       wr_valid;
   logic       wr_sof;
   logic       wr_last;
   sample_t    wr_data;

   // field falls at the start of each frame
   assign new_frame = field_d && !timing.field;

   always_comb
   begin
      state_nx = state;
      case (state)
         RX_IDLE:
         begin
            if (new_frame)
               state_nx = RX_SAV;
         end
         RX_SAV, RX_BLANKING:
         begin
            // vblank is valid once sav_d fires
            if (sav_d)
               state_nx = timing.vblank ? RX_BLANKING : RX_VDATA;
         end
         RX_VDATA:
         begin
            if (timing.hdr)
               state_nx = RX_BLANKING;
         end
         default:
            state_nx = RX_IDLE;
      endcase
   end

   assign capture  = (state == RX_VDATA) && (skip == 2'd0) && !timing.hdr;
   assign line_end = (state == RX_VDATA) && timing.hdr;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state       <= RX_IDLE;
         field_d     <= 1'b0;
         sav_d       <= 1'b0;
         skip        <= 2'd0;
         sof_pending <= 1'b0;
         hold_valid  <= 1'b0;
         wr_valid    <= 1'b0;
      end
      else
      begin
         state   <= state_nx;
         field_d <= timing.field;
         sav_d   <= timing.sav;
         // FF and the first 00 are already past tap when sav_d fires
         if (state_nx == RX_VDATA && state != RX_VDATA)
            skip <= 2'(PREAMBLE_LEN - 2);
         else if (state == RX_VDATA && skip != 2'd0)
            skip <= skip - 2'd1;
         if (new_frame)
            sof_pending <= 1'b1;
         else if (capture)
            sof_pending <= 1'b0;
         // the held sample goes out when the next one arrives or the line ends
         wr_valid <= (capture || line_end) && hold_valid;
         if (capture)
            hold_valid <= 1'b1;
         else if (line_end)
            hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (capture || line_end)
      begin
         wr_data <= hold_data;
         wr_sof  <= hold_sof;
         wr_last <= line_end;
      end
      if (capture)
      begin
         hold_data <= timing.tap;
         hold_sof  <= sof_pending;
      end
   end

   assign wr.valid = wr_valid;
   assign wr.data  = wr_data;
   assign wr.sof   = wr_sof;
   assign wr.last  = wr_last;

endmodule

/* frame_size_monitor.sv */
`timescale 1ns/1ns

module frame_size_monitor
   import bt656_pkg::*, stream_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   video_timing_if.snk timing,
   input  logic        status_clr_i,
   output size_t       width_o,
   output size_t       height_o,
   output logic        width_err_o,
   output logic        height_err_o,
   output frame_cnt_t  frame_cnt_o
);

   logic  field_d;
   logic  new_frame;
   logic  in_line;
   logic  active_eol;
   size_t pix_cnt;
   size_t line_cnt;
   size_t line_width;

   assign new_frame = field_d && !timing.field;

   // pix_cnt also counts the 00 00 XY bytes after the SAV, two samples per pixel
   assign line_width = (pix_cnt - size_t'(PREAMBLE_LEN - 1)) >> 1;

   // line_cnt stays unset until the first frame boundary
   assign active_eol = timing.eav && in_line && !timing.vblank && (line_cnt != CNT_UNSET);

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         field_d      <= 1'b0;
         in_line      <= 1'b0;
         pix_cnt      <= '0;
         line_cnt     <= CNT_UNSET;
         width_o      <= CNT_UNSET;
         height_o     <= CNT_UNSET;
         width_err_o  <= 1'b0;
         height_err_o <= 1'b0;
         frame_cnt_o  <= '0;
      end
      else
      begin
         field_d <= timing.field;
         if (status_clr_i)
         begin
            width_err_o  <= 1'b0;
            height_err_o <= 1'b0;
         end
         if (timing.sav)
         begin
            in_line <= 1'b1;
            pix_cnt <= '0;
         end
         else if (timing.eav)
            in_line <= 1'b0;
         else if (in_line)
            pix_cnt <= pix_cnt + 1'b1;
         if (active_eol)
         begin
            if (width_o != CNT_UNSET && line_width != width_o)
               width_err_o <= 1'b1;
            width_o  <= line_width;
            line_cnt <= line_cnt + 1'b1;
         end
         if (new_frame)
         begin
            if (line_cnt != CNT_UNSET)
            begin
               if (height_o != CNT_UNSET && line_cnt != height_o)
                  height_err_o <= 1'b1;
               height_o <= line_cnt;
            end
            line_cnt    <= '0;
            frame_cnt_o <= frame_cnt_o + 1'b1;
         end
      end
   end

endmodule

/* line_fifo.sv */
`timescale 1ns/1ns

module line_fifo
   import bt656_pkg::*, stream_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   pixel_stream_if.snk wr,
   pixel_stream_if.src rd,
   output logic        line_ready_o,
   input  logic        status_clr_i,
   output logic        overflow_o
);

   typedef struct packed {
      logic    sof;
      logic    last;
      sample_t data;
   } entry_t;

   entry_t             mem [FIFO_DEPTH];
   entry_t             head;
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;
   logic [FIFO_AW:0]   lines;
   logic               push;
   logic               pop;

   assign wr.ready = (count != (FIFO_AW+1)'(FIFO_DEPTH));
   assign push     = wr.valid && wr.ready;
   assign pop      = rd.valid && rd.ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= '{sof: wr.sof, last: wr.last, data: wr.data};
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         lines      <= '0;
         overflow_o <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (FIFO_AW+1)'(push) - (FIFO_AW+1)'(pop);
         // a line counts once its last sample is stored
         lines <= lines + (FIFO_AW+1)'(push && wr.last) - (FIFO_AW+1)'(pop && head.last);
         if (status_clr_i)
            overflow_o <= 1'b0;
         if (wr.valid && !wr.ready)
            overflow_o <= 1'b1;
      end
   end

   assign head         = mem[rd_ptr];
   assign rd.valid     = (count != '0);
   assign rd.data      = head.data;
   assign rd.sof       = head.sof;
   assign rd.last      = head.last;
   assign line_ready_o = (lines != '0);

endmodule

/* stream_out.sv */
`timescale 1ns/1ns

module stream_out
   import bt656_pkg::*, stream_pkg::*;
(
   input  logic        clk,
   input  logic        rstn,
   pixel_stream_if.snk rd,
   input  logic        line_ready_i,
   input  logic        m_ready_i,
   output logic        m_valid_o,
   output sample_t     m_data_o,
   output logic        m_sof_o,
   output logic        m_last_o
);

   out_state_t state;
   logic       advance;
   logic       done;
   logic       pop;

   // output register is free, or its sample is taken this cycle
   assign advance = !m_valid_o || m_ready_i;
   assign done    = m_valid_o && m_last_o && m_ready_i;

   // no fetch beyond the last sample of the line
   assign rd.ready = (state != OUT_IDLE) && advance && !(m_valid_o && m_last_o);
   assign pop      = rd.ready && rd.valid;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state     <= OUT_IDLE;
         m_valid_o <= 1'b0;
         m_sof_o   <= 1'b0;
         m_last_o  <= 1'b0;
      end
      else
      begin
         case (state)
            OUT_IDLE:
            begin
               if (line_ready_i)
                  state <= OUT_SOF;
            end
            OUT_SOF:
            begin
               // a whole line is buffered, so the head is there
               if (pop)
                  state <= OUT_DATA;
            end
            OUT_DATA:
            begin
               if (done)
                  state <= OUT_IDLE;
            end
            default:
               state <= OUT_IDLE;
         endcase
         if (done)
         begin
            m_valid_o <= 1'b0;
            m_sof_o   <= 1'b0;
            m_last_o  <= 1'b0;
         end
         else if (state != OUT_IDLE && advance)
         begin
            m_valid_o <= pop;
            m_sof_o   <= pop && rd.sof;
            m_last_o  <= pop && rd.last;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
         m_data_o <= rd.data;
   end

endmodule

/* bt656_rx_top.sv */
`timescale 1ns/1ns

module bt656_rx_top
   import bt656_pkg::*, stream_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  sample_t    video_i,
   input  logic       m_ready_i,
   output logic       m_valid_o,
   output sample_t    m_data_o,
   output logic       m_sof_o,
   output logic       m_last_o,
   input  logic       status_clr_i,
   output size_t      width_o,
   output size_t      height_o,
   output logic       width_err_o,
   output logic       height_err_o,
   output logic       overflow_o,
   output frame_cnt_t frame_cnt_o
);

   logic line_ready;

   video_timing_if timing ();
   // framer to FIFO, then FIFO to output stage
   pixel_stream_if wr_link ();
   pixel_stream_if rd_link ();

   bt656_header_detect u_header_detect (
      .clk     (clk),
      .rstn    (rstn),
      .video_i (video_i),
      .timing  (timing)
   );

   bt656_line_framer u_line_framer (
      .clk    (clk),
      .rstn   (rstn),
      .timing (timing),
      .wr     (wr_link)
   );

   frame_size_monitor u_size_monitor (
      .clk          (clk),
      .rstn         (rstn),
      .timing       (timing),
      .status_clr_i (status_clr_i),
      .width_o      (width_o),
      .height_o     (height_o),
      .width_err_o  (width_err_o),
      .height_err_o (height_err_o),
      .frame_cnt_o  (frame_cnt_o)
   );

   line_fifo u_line_fifo (
      .clk          (clk),
      .rstn         (rstn),
      .wr           (wr_link),
      .rd           (rd_link),
      .line_ready_o (line_ready),
      .status_clr_i (status_clr_i),
      .overflow_o   (overflow_o)
   );

   stream_out u_stream_out (
      .clk          (clk),
      .rstn         (rstn),
      .rd           (rd_link),
      .line_ready_i (line_ready),
      .m_ready_i    (m_ready_i),
      .m_valid_o    (m_valid_o),
      .m_data_o     (m_data_o),
      .m_sof_o      (m_sof_o),
      .m_last_o     (m_last_o)
   );

endmodule

/* bt656_rx_checker.sv */
`timescale 1ns/1ns

module bt656_rx_checker
   import bt656_pkg::*;
(
   input logic    clk,
   input logic    rstn,
   input logic    m_ready_i,
   input logic    m_valid_o,
   input sample_t m_data_o,
   input logic    m_sof_o,
   input logic    m_last_o
);

   logic in_line;
   logic hold_fail = 1'b0;
   logic tag_fail  = 1'b0;
   logic sof_fail  = 1'b0;
   logic failed;

   // high between a transfer that did not end a line and the line's last transfer
   always_ff @(posedge clk)
   begin
      if (!rstn)
         in_line <= 1'b0;
      else if (m_valid_o && m_ready_i)
         in_line <= !m_last_o;
   end

   assign failed = hold_fail || tag_fail || sof_fail;

   hold_while_stalled: assert property (@(posedge clk) disable iff (!rstn)
      m_valid_o && !m_ready_i |=>
         m_valid_o && $stable(m_data_o) && $stable(m_sof_o) && $stable(m_last_o))
   else
   begin
      hold_fail = 1'b1;
      $error("output sample changed while m_ready_i was low");
   end

   tags_with_valid: assert property (@(posedge clk) disable iff (!rstn)
      (m_sof_o || m_last_o) |-> m_valid_o)
   else
   begin
      tag_fail = 1'b1;
      $error("m_sof_o or m_last_o high without m_valid_o");
   end

   no_sof_mid_line: assert property (@(posedge clk) disable iff (!rstn)
      m_valid_o && m_sof_o |-> !in_line)
   else
   begin
      sof_fail = 1'b1;
      $error("m_sof_o inside a line");
   end

endmodule

bind bt656_rx_top bt656_rx_checker u_checker (
   .clk       (clk),
   .rstn      (rstn),
   .m_ready_i (m_ready_i),
   .m_valid_o (m_valid_o),
   .m_data_o  (m_data_o),
   .m_sof_o   (m_sof_o),
   .m_last_o  (m_last_o)
);

/* tb_bt656_rx.sv */
`timescale 1ns/1ns

module tb_bt656_rx
   import bt656_pkg::*, stream_pkg::*;
();

   localparam int W             = 8;
   localparam int W_WIDE        = 10;
   localparam int LINES         = 4;
   localparam int BLANK_N       = 40;
   localparam int DRAIN_TIMEOUT = 5000;

   // one output transfer with its tags
   typedef struct packed {
      logic    sof;
      logic    last;
      sample_t data;
   } beat_t;

   logic        clk;
   logic        rstn;
   sample_t     video;
   logic        m_ready = 1'b1;
   logic        m_valid;
   sample_t     m_data;
   logic        m_sof;
   logic        m_last;
   logic        status_clr;
   size_t       width;
   size_t       height;
   logic        width_err;
   logic        height_err;
   logic        overflow;
   frame_cnt_t  frame_cnt;

   beat_t       expq [$];
   logic [31:0] data_rng;
   logic [31:0] ready_rng = 32'h77;
   logic        random_ready;
   int          frames;
   int          last_w;
   int          last_h;
   logic        exp_werr;
   logic        exp_herr;

   bt656_rx_top uut (
      .clk          (clk),
      .rstn         (rstn),
      .video_i      (video),
      .m_ready_i    (m_ready),
      .m_valid_o    (m_valid),
      .m_data_o     (m_data),
      .m_sof_o      (m_sof),
      .m_last_o     (m_last),
      .status_clr_i (status_clr),
      .width_o      (width),
      .height_o     (height),
      .width_err_o  (width_err),
      .height_err_o (height_err),
      .overflow_o   (overflow),
      .frame_cnt_o  (frame_cnt)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #5 clk = ~clk;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // XY byte with its protection bits
   function automatic sample_t xy_byte(input logic f, input logic v, input logic h);
      return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h};
   endfunction

   // expected tags for sample pos of a line with len samples
   function automatic beat_t expected_beat(input sample_t d, input int pos, input int len,
                                           input logic first_line);
      beat_t b;
      b.data = d;
      b.sof  = first_line && (pos == 0);
      b.last = (pos == len - 1);
      return b;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic compare_flag(input string name, input logic got, input logic want);
      if (got !== want)
         abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                             $time, name, got, want));
   endtask

   task automatic compare_size(input string name, input size_t got, input size_t want);
      if (got !== want)
         abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                             $time, name, got, want));
   endtask

   task automatic compare_count(input string name, input frame_cnt_t got,
                                input frame_cnt_t want);
      if (got !== want)
         abort_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                             $time, name, got, want));
   endtask

   task automatic compare_sample(input beat_t got, input beat_t want);
      if (got.data !== want.data)
         abort_run($sformatf("mismatch at %0t: m_data_o is %h, expected %h",
                             $time, got.data, want.data));
      compare_flag("m_sof_o", got.sof, want.sof);
      compare_flag("m_last_o", got.last, want.last);
   endtask

   // the previous frame is settled once the new frame's blanking has passed
   task automatic check_status();
      compare_size("width_o", width, (last_w < 0) ? CNT_UNSET : size_t'(last_w));
      compare_size("height_o", height, (last_h < 0) ? CNT_UNSET : size_t'(last_h));
      compare_count("frame_cnt_o", frame_cnt, frame_cnt_t'(frames));
      compare_flag("width_err_o", width_err, exp_werr);
      compare_flag("height_err_o", height_err, exp_herr);
      compare_flag("overflow_o", overflow, 1'b0);
   endtask

   task automatic put_byte(input sample_t b);
      @(posedge clk);
      video <= b;
   endtask

   task automatic put_header(input logic f, input logic v, input logic h);
      put_byte(PREAMBLE_FF);
      put_byte(PREAMBLE_00);
      put_byte(PREAMBLE_00);
      put_byte(xy_byte(f, v, h));
   endtask

   task automatic put_fill(input int n);
      for (int i = 0; i < n; i++)
      begin
         put_byte(i[0] ? 8'h10 : 8'h80);
      end
   endtask

   task automatic send_line(input logic f, input logic v, input int n, input logic expect_out,
                            input logic first_line);
      sample_t d;
      put_header(f, v, 1'b1);
      put_fill(BLANK_N);
      put_header(f, v, 1'b0);
      for (int i = 0; i < n; i++)
      begin
         if (v)
            d = i[0] ? 8'h10 : 8'h80;
         else
         begin
            data_rng = xorshift(data_rng);
            d = data_rng[7:0];
            // 00 and FF are reserved for timing references
            if (d == PREAMBLE_00 || d == PREAMBLE_FF)
               d = 8'h5A;
         end
         if (expect_out)
            expq.push_back(expected_beat(d, i, n, first_line));
         put_byte(d);
      end
   endtask

   task automatic pulse_clear();
      status_clr <= 1'b1;
      put_fill(1);
      status_clr <= 1'b0;
      put_fill(2);
      exp_werr = 1'b0;
      exp_herr = 1'b0;
      compare_flag("width_err_o", width_err, 1'b0);
      compare_flag("height_err_o", height_err, 1'b0);
   endtask

   // wide_line selects one line of W_WIDE, a negative value means none
   task automatic send_frame(input int nlines, input int wide_line, input logic clear);
      int w;
      send_line(1'b1, 1'b1, 2 * W, 1'b0, 1'b0);
      for (int b = 0; b < 2; b++)
      begin
         send_line(1'b0, 1'b1, 2 * W, 1'b0, 1'b0);
      end
      frames++;
      check_status();
      if (clear)
         pulse_clear();
      for (int l = 0; l < nlines; l++)
      begin
         w = (l == wide_line) ? W_WIDE : W;
         if (last_w >= 0 && w != last_w)
            exp_werr = 1'b1;
         last_w = w;
         send_line(1'b0, 1'b0, 2 * w, 1'b1, l == 0);
      end
      if (nlines > 0)
      begin
         if (last_h >= 0 && nlines != last_h)
            exp_herr = 1'b1;
         last_h = nlines;
      end
   endtask

   always @(posedge clk)
   begin
      ready_rng = xorshift(ready_rng);
      m_ready <= random_ready ? (ready_rng[3] | ready_rng[9]) : 1'b1;
   end

   // compares every output transfer with the head of the expected queue
   always @(posedge clk)
   begin
      beat_t got;
      if (m_valid && m_ready)
      begin
         got = {m_sof, m_last, m_data};
         if (expq.size() == 0)
            abort_run("an output sample appeared when none was expected");
         else
            compare_sample(got, expq.pop_front());
      end
      if (uut.u_checker.failed)
         abort_run("an output protocol assertion failed");
   end

   initial
   begin
      rstn         = 1'b0;
      video        = 8'h10;
      status_clr   = 1'b0;
      random_ready = 1'b0;
      data_rng     = 32'h77;
      frames       = 0;
      last_w       = -1;
      last_h       = -1;
      exp_werr     = 1'b0;
      exp_herr     = 1'b0;
      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      compare_flag("m_valid_o", m_valid, 1'b0);
      compare_flag("m_sof_o", m_sof, 1'b0);
      compare_flag("m_last_o", m_last, 1'b0);
      check_status();

      // active line before any frame start must not come out
      send_line(1'b0, 1'b0, 2 * W, 1'b0, 1'b0);
      for (int k = 0; k < 3; k++)
      begin
         send_frame(LINES, -1, 1'b0);
      end
      send_frame(LINES, 1, 1'b0);
      send_frame(LINES + 1, -1, 1'b0);
      send_frame(LINES, -1, 1'b0);

      random_ready <= 1'b1;
      send_frame(LINES, -1, 1'b1);
      for (int k = 0; k < 3; k++)
      begin
         send_frame(LINES, -1, 1'b0);
      end
      // closing field-1 and blanking lines report the final frame
      send_frame(0, -1, 1'b0);

      for (int t = 0; t < DRAIN_TIMEOUT && expq.size() != 0; t++)
      begin
         @(posedge clk);
      end
      @(posedge clk);
      compare_flag("overflow_o", overflow, 1'b0);
      if (expq.size() != 0)
         abort_run("timeout while waiting for the remaining samples on the output");
      else if (uut.u_checker.failed)
         abort_run("an output protocol assertion failed");
      else
      begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

/* bt656_rx.f */
bt656_pkg.sv
stream_pkg.sv
video_timing_if.sv
pixel_stream_if.sv
bt656_header_detect.sv
bt656_line_framer.sv
frame_size_monitor.sv
line_fifo.sv
stream_out.sv
bt656_rx_top.sv
bt656_rx_checker.sv
tb_bt656_rx.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_bt656_rx -f bt656_rx.f --Mdir obj_dir -o sim_bt656_rx \
   || exit 1
out=$(./obj_dir/sim_bt656_rx +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1
